// ==== project.f ====
+incdir+tests
source/fir_pkg.sv
source/frame_pkg.sv
source/fir_tap_line.sv
source/fir_mac.sv
source/frame_collector.sv
source/fas_top.sv
tests/fas_tb.sv

// ==== tests/fas_tb_model.svh ====
// Reference model for the filter front end
// Tap line with fill count, FIR sum and rounding, frame buffer
// Impulse response helper for the direct coefficient check

fir_pkg::sample_t mdl_taps [fir_pkg::NUM_TAPS];    // Tap 0 newest
int               mdl_fill;                        // Consecutive samples seen
logic             pend_v [2];                      // Words in flight, index 1 leaves next
fir_pkg::sample_t pend_d [2];
logic             pend_cv [2];                     // Impulse expectation riding along
fir_pkg::sample_t pend_cd [2];
logic             mdl_out_v;
fir_pkg::sample_t mdl_out_d;
logic             mdl_chk_v;
fir_pkg::sample_t mdl_chk_d;
fir_pkg::sample_t mdl_frame_buf [FRAME_LEN];
fir_pkg::sample_t mdl_frame_snap [FRAME_LEN];      // Last completed frame
int               mdl_frame_idx;
logic             mdl_frame_due;
logic             mdl_frame_v;

// Q16 sum back to 16 bits, negative values moved up by one
function automatic fir_pkg::sample_t fir_round(input longint sum);
  longint           shifted;
  fir_pkg::sample_t res;
  shifted = sum >>> fir_pkg::OUT_SHIFT;
  res     = fir_pkg::sample_t'(shifted);
  if (sum < 0) begin
    res = res + 16'sd1;
  end
  return res;
endfunction

function automatic longint window_sum();
  longint acc;
  acc = 0;
  for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
    acc = acc + longint'(mdl_taps[k]) * longint'(fir_pkg::FIR_COEFS[k]);
  end
  return acc;
endfunction

// Output k of an isolated impulse of height amp
function automatic fir_pkg::sample_t impulse_response(input int amp, input int k);
  return fir_round(longint'(amp) * longint'(fir_pkg::FIR_COEFS[k]));
endfunction

task automatic model_reset();
  for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
    mdl_taps[k] = '0;
  end
  for (int i = 0; i < FRAME_LEN; i++) begin
    mdl_frame_buf[i]  = '0;
    mdl_frame_snap[i] = '0;
  end
  for (int j = 0; j < 2; j++) begin
    pend_v[j]  = 1'b0;
    pend_d[j]  = '0;
    pend_cv[j] = 1'b0;
    pend_cd[j] = '0;
  end
  mdl_fill      = 0;
  mdl_out_v     = 1'b0;
  mdl_out_d     = '0;
  mdl_chk_v     = 1'b0;
  mdl_chk_d     = '0;
  mdl_frame_idx = 0;
  mdl_frame_due = 1'b0;
  mdl_frame_v   = 1'b0;
endtask

// One rising edge with the given inputs
task automatic model_edge(input logic dv, input fir_pkg::sample_t d,
                          input logic chk_v, input fir_pkg::sample_t chk_d);
  logic full;
  mdl_frame_v   = mdl_frame_due;                   // Strobe trails the closing word
  mdl_frame_due = 1'b0;
  mdl_out_v     = pend_v[1];
  if (pend_v[1]) begin
    mdl_out_d = pend_d[1];
  end
  mdl_chk_v  = pend_cv[1];
  mdl_chk_d  = pend_cd[1];
  pend_v[1]  = pend_v[0];
  pend_d[1]  = pend_d[0];
  pend_cv[1] = pend_cv[0];
  pend_cd[1] = pend_cd[0];
  full       = 1'b0;
  if (dv) begin
    for (int k = fir_pkg::NUM_TAPS - 1; k > 0; k--) begin
      mdl_taps[k] = mdl_taps[k-1];
    end
    mdl_taps[0] = d;
    if (mdl_fill < fir_pkg::NUM_TAPS) begin
      mdl_fill++;
    end
    full = (mdl_fill == fir_pkg::NUM_TAPS);
  end else begin
    mdl_fill = 0;                                  // Gap restarts the window
  end
  pend_v[0]  = full;
  pend_d[0]  = full ? fir_round(window_sum()) : '0;
  pend_cv[0] = full && chk_v;
  pend_cd[0] = chk_d;
  if (mdl_out_v) begin
    mdl_frame_buf[mdl_frame_idx] = mdl_out_d;
    if (mdl_frame_idx == FRAME_LEN - 1) begin
      mdl_frame_snap = mdl_frame_buf;
      mdl_frame_due  = 1'b1;
      mdl_frame_idx  = 0;
    end else begin
      mdl_frame_idx++;
    end
  end
endtask

// ==== tests/fas_tb.sv ====
// Testbench for the filter front end
// Clock, reset, stimulus table loop and timeout
// Checks filtered words, impulse response, frame strobes and contents

`timescale 1ns/1ns

module fas_tb;

  localparam int FRAME_LEN = frame_pkg::FRAME_LEN_DEFAULT;
  localparam int NUM_ROWS  = 9;
  localparam int DRAIN     = 4;                    // Idle cycles to flush the pipeline

  typedef enum int {IMPULSE, STEP, RANDOM, GAP} kind_e;

  typedef struct packed {
    kind_e kind;
    int    count;                                  // Cycles in the row
    int    amp;
    int    windows;                                // Full windows closed by the row
  } row_t;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  localparam row_t ROWS [NUM_ROWS] = '{
    '{STEP,    20,   1000,  0},                    // Partial fill from reset
    '{IMPULSE, 63,  20000, 52},
    '{RANDOM,  60,  32767, 60},
    '{GAP,     45,  30000, 13},                    // First cycle idle
    '{STEP,    40, -25000, 40},                    // Negative sums
    '{IMPULSE, 63, -32768, 63},
    '{RANDOM,  50,  32767, 50},
    '{GAP,      2,   1000,  0},
    '{RANDOM,  40,  32767, 10}
  };

  logic                clk;
  logic                rst;
  logic                data_valid;
  fir_pkg::sample_t    data;
  frame_pkg::fir_out_t fir_out;
  fir_pkg::sample_t    frame [FRAME_LEN];
  logic                frame_valid;

  int err_cnt;
  int check_cnt;
  int out_cnt;
  int frame_cnt;
  int cycle_cnt;
  int cycle_limit;
  int dut_win [NUM_ROWS];                          // Filter outputs credited to each row
  int row_hist [2];                                // Rows of the last two driven cycles

  `include "fas_tb_model.svh"

  fas_top #(
    .FRAME_LEN (FRAME_LEN)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_out     (fir_out),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic string kind_text(input kind_e kind);
    case (kind)
      IMPULSE: return "impulse";
      STEP:    return "step";
      RANDOM:  return "random";
      default: return "gap";
    endcase
  endfunction

  function automatic fir_pkg::sample_t random_sample(input int amp);
    int span;
    span = (amp < 0) ? -amp : amp;
    return fir_pkg::sample_t'(int'($urandom_range(2 * span)) - span);
  endfunction

  task automatic record_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic check_outputs(input int src_row);
    check_cnt++;
    assert (fir_out.valid == mdl_out_v) else begin
      if (mdl_out_v) begin
        record_error($sformatf("ERROR: filter output strobe missing at %0t ns", $time));
      end else begin
        record_error($sformatf("ERROR: unexpected filter output strobe at %0t ns", $time));
      end
    end
    if (fir_out.valid) begin
      out_cnt++;
      if (src_row >= 0) begin
        dut_win[src_row]++;
      end
    end
    if (mdl_out_v && fir_out.valid) begin
      check_cnt++;
      assert (fir_out.data == mdl_out_d) else
        record_error($sformatf("MISMATCH %0t ns fir_out.data %0d expected %0d",
                               $time, fir_out.data, mdl_out_d));
    end
    if (mdl_chk_v && fir_out.valid) begin
      check_cnt++;
      assert (fir_out.data == mdl_chk_d) else
        record_error($sformatf("MISMATCH %0t ns impulse response %0d expected %0d",
                               $time, fir_out.data, mdl_chk_d));
    end
    check_cnt++;
    assert (frame_valid == mdl_frame_v) else begin
      if (mdl_frame_v) begin
        record_error($sformatf("ERROR: frame strobe missing at %0t ns", $time));
      end else begin
        record_error($sformatf("ERROR: unexpected frame strobe at %0t ns", $time));
      end
    end
    if (frame_valid) begin
      frame_cnt++;
    end
    if (mdl_frame_v && frame_valid) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        check_cnt++;
        assert (frame[i] == mdl_frame_snap[i]) else
          record_error($sformatf("MISMATCH %0t ns frame slot %0d is %0d expected %0d",
                                 $time, i, frame[i], mdl_frame_snap[i]));
      end
    end
  endtask

  // Drive on the falling edge, then look at the results one cycle later
  task automatic drive_cycle(input int row, input logic dv, input fir_pkg::sample_t d,
                             input logic chk_v, input fir_pkg::sample_t chk_d);
    data_valid = dv;
    data       = d;
    model_edge(dv, d, chk_v, chk_d);
    @(negedge clk);
    check_outputs(row_hist[1]);
    row_hist[1] = row_hist[0];
    row_hist[0] = row;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic             dv;
    logic             chk_v;
    fir_pkg::sample_t d;
    fir_pkg::sample_t chk_d;
    int               row_err;
    int               exp_total;
    clk         = 1'b0;
    rst         = 1'b1;
    data_valid  = 1'b0;
    data        = '0;
    err_cnt     = 0;
    check_cnt   = 0;
    out_cnt     = 0;
    frame_cnt   = 0;
    cycle_cnt   = 0;
    row_hist[0] = -1;
    row_hist[1] = -1;
    void'($urandom(32'h2b3));
    cycle_limit = 50;
    exp_total   = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit = cycle_limit + ROWS[r].count + 3;
      exp_total   = exp_total + ROWS[r].windows;
      dut_win[r]  = 0;
    end
    model_reset();

    repeat (5) begin
      @(negedge clk);
      check_cnt++;
      assert (!fir_out.valid && !frame_valid) else
        record_error("ERROR: output strobe high while reset is asserted");
    end
    rst = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      row_err = err_cnt;
      for (int i = 0; i < ROWS[r].count; i++) begin
        dv    = 1'b1;
        chk_v = 1'b0;
        chk_d = '0;
        case (ROWS[r].kind)
          IMPULSE: begin
            d = (i == fir_pkg::NUM_TAPS - 1) ? fir_pkg::sample_t'(ROWS[r].amp) : '0;
            if (i >= fir_pkg::NUM_TAPS - 1) begin
              chk_v = 1'b1;
              chk_d = impulse_response(ROWS[r].amp, i - (fir_pkg::NUM_TAPS - 1));
            end
          end
          STEP:    d = fir_pkg::sample_t'(ROWS[r].amp);
          RANDOM:  d = random_sample(ROWS[r].amp);
          default: begin
            dv = (i != 0);                         // One idle cycle opens the row
            d  = random_sample(ROWS[r].amp);
          end
        endcase
        drive_cycle(r, dv, d, chk_v, chk_d);
      end
      $display("row %0d %s cycles %0d errors %0d", r, kind_text(ROWS[r].kind),
               ROWS[r].count, err_cnt - row_err);
    end

    repeat (DRAIN) begin
      drive_cycle(-1, 1'b0, '0, 1'b0, '0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      check_cnt++;
      assert (dut_win[r] == ROWS[r].windows) else
        record_error($sformatf("ERROR: row %0d gave %0d filter outputs instead of %0d",
                               r, dut_win[r], ROWS[r].windows));
    end
    check_cnt++;
    assert (frame_cnt == exp_total / FRAME_LEN) else
      record_error($sformatf("ERROR: %0d frames seen instead of %0d",
                             frame_cnt, exp_total / FRAME_LEN));

    $display("checks %0d errors %0d outputs %0d frames %0d",
             check_cnt, err_cnt, out_cnt, frame_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/fas_top.sv ====
// Frequency analysis front end top level
// Chains the tap line, the FIR MAC and the frame collector

`timescale 1ns/1ns

module fas_top #(
  parameter int FRAME_LEN = frame_pkg::FRAME_LEN_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                data_valid,                 // Input sample strobe
  input  fir_pkg::sample_t    data,                       // Input sample
  output frame_pkg::fir_out_t fir_out,                    // Filtered word and strobe
  output fir_pkg::sample_t    frame [FRAME_LEN],          // Slot 0 is the oldest
  output logic                frame_valid                 // Frame complete
);

  fir_pkg::sample_t taps [fir_pkg::NUM_TAPS];             // Current window
  logic             window_ready;

  //////////////////////////////////////////////////////////////////////
  // Filter
  //////////////////////////////////////////////////////////////////////

  fir_tap_line u_tap_line (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (data_valid),
    .data         (data),
    .taps         (taps),
    .window_ready (window_ready)
  );

  fir_mac u_mac (
    .clk          (clk),
    .rst          (rst),
    .taps         (taps),
    .window_ready (window_ready),
    .fir_out      (fir_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Framing
  //////////////////////////////////////////////////////////////////////

  frame_collector #(
    .FRAME_LEN (FRAME_LEN)
  ) u_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_out     (fir_out),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

endmodule

// ==== source/frame_collector.sv ====
// Serial to parallel framing
// Collects consecutive filtered samples into frames of FRAME_LEN words
// Publishes the finished frame with a one cycle strobe

`timescale 1ns/1ns

module frame_collector #(
  parameter int FRAME_LEN = 16                            // Words per frame
) (
  input  logic                clk,
  input  logic                rst,
  input  frame_pkg::fir_out_t fir_out,                    // Filtered word and strobe
  output fir_pkg::sample_t    frame [FRAME_LEN],          // Slot 0 is the oldest
  output logic                frame_valid                 // Frame complete
);

  localparam int IDX_W = $clog2(FRAME_LEN);

  logic [IDX_W-1:0] wr_idx;                               // Next slot to write
  logic             last_slot;
  fir_pkg::sample_t hold_q [FRAME_LEN-1];                 // Words of the frame in progress

  assign last_slot = (wr_idx == IDX_W'(FRAME_LEN - 1));

  //////////////////////////////////////////////////////////////////////
  // Write index
  //////////////////////////////////////////////////////////////////////

  // Advances only on filtered words so frames run across input gaps
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_idx <= '0;
    end else if (fir_out.valid) begin
      wr_idx <= last_slot ? '0 : wr_idx + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot storage
  //////////////////////////////////////////////////////////////////////

  // Early words wait here until the last one arrives
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < FRAME_LEN - 1; i++) begin
        hold_q[i] <= '0;
      end
    end else if (fir_out.valid && !last_slot) begin
      hold_q[wr_idx] <= fir_out.data;
    end
  end

  // Whole frame moves out at once so the next frame can start filling
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        frame[i] <= '0;
      end
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= fir_out.valid && last_slot;
      if (fir_out.valid && last_slot) begin
        for (int i = 0; i < FRAME_LEN - 1; i++) begin
          frame[i] <= hold_q[i];
        end
        frame[FRAME_LEN-1] <= fir_out.data;               // Newest word closes the frame
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_idx_in_range: assert property (
    @(posedge clk) disable iff (rst)
    wr_idx <= IDX_W'(FRAME_LEN - 1)
  ) else $error("frame write index out of range");

endmodule

// ==== source/fir_mac.sv ====
// FIR multiply accumulate
// Sums the 32 tap products into a registered accumulator
// Rounds the sum to 16 bits with sign correction and emits the filtered word

`timescale 1ns/1ns

module fir_mac (
  input  logic                clk,
  input  logic                rst,
  input  fir_pkg::sample_t    taps [fir_pkg::NUM_TAPS],   // Window with tap 0 newest
  input  logic                window_ready,               // Window is valid this cycle
  output frame_pkg::fir_out_t fir_out                     // Rounded result and strobe
);

  localparam int ACC_W = $bits(fir_pkg::acc_t);
  localparam int SMP_W = $bits(fir_pkg::sample_t);

  fir_pkg::acc_t    mac_sum;                              // Combinational dot product
  fir_pkg::acc_t    sum_q;                                // Registered sum
  logic             sum_vld_q;                            // Sum loaded last edge
  fir_pkg::acc_t    sum_shift;
  fir_pkg::sample_t rnd_data;

  //////////////////////////////////////////////////////////////////////
  // Products and sum
  //////////////////////////////////////////////////////////////////////

  // Both operands are widened before the multiply so signs carry through
  always_comb begin
    mac_sum = '0;
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
      mac_sum = mac_sum + fir_pkg::acc_t'(taps[k]) * fir_pkg::acc_t'(fir_pkg::FIR_COEFS[k]);
    end
  end

  // Taps are sampled before the next shift so the window is still intact
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum_q     <= '0;
      sum_vld_q <= 1'b0;
    end else begin
      sum_vld_q <= window_ready;
      if (window_ready) begin
        sum_q <= mac_sum;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output rounding
  //////////////////////////////////////////////////////////////////////

  // Drop the Q16 fraction and keep the low 16 bits
  // Negative sums get one added back toward zero
  always_comb begin
    sum_shift = sum_q >>> fir_pkg::OUT_SHIFT;
    rnd_data  = sum_shift[SMP_W-1:0] + SMP_W'(sum_q[ACC_W-1]);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_out <= '0;
    end else begin
      fir_out.valid <= sum_vld_q;                         // Single cycle strobe
      if (sum_vld_q) begin
        fir_out.data <= rnd_data;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Every output word traces back to a full window two edges earlier
  a_out_from_window: assert property (
    @(posedge clk) disable iff (rst)
    fir_out.valid |-> $past(window_ready, 2)
  ) else $error("filter output without a full window");

endmodule

// ==== source/fir_tap_line.sv ====
// FIR input delay line
// Shifts accepted samples into a 32 deep tap line with tap 0 newest
// Counts consecutive samples and flags a complete window

`timescale 1ns/1ns

module fir_tap_line (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,                   // Sample strobe
  input  fir_pkg::sample_t  data,                         // New sample
  output fir_pkg::sample_t  taps [fir_pkg::NUM_TAPS],     // Delay line with tap 0 newest
  output logic              window_ready                  // Last NUM_TAPS samples consecutive
);

  localparam int CNT_W = $clog2(fir_pkg::NUM_TAPS + 1);

  logic [CNT_W-1:0] fill_cnt;                             // Consecutive samples seen
  logic [CNT_W-1:0] fill_nxt;

  //////////////////////////////////////////////////////////////////////
  // Fill counter
  //////////////////////////////////////////////////////////////////////

  // Saturates at a full window and restarts on any idle cycle
  always_comb begin
    if (!data_valid) begin
      fill_nxt = '0;                                      // Gap breaks the run
    end else if (fill_cnt == CNT_W'(fir_pkg::NUM_TAPS)) begin
      fill_nxt = fill_cnt;                                // Hold at full
    end else begin
      fill_nxt = fill_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt     <= '0;
      window_ready <= 1'b0;
    end else begin
      fill_cnt     <= fill_nxt;
      window_ready <= data_valid && (fill_nxt == CNT_W'(fir_pkg::NUM_TAPS));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Delay line
  //////////////////////////////////////////////////////////////////////

  // Taps keep their contents through gaps
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
        taps[k] <= '0;
      end
    end else if (data_valid) begin
      taps[0] <= data;                                    // Newest sample enters here
      for (int k = 1; k < fir_pkg::NUM_TAPS; k++) begin
        taps[k] <= taps[k-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_fill_in_range: assert property (
    @(posedge clk) disable iff (rst)
    fill_cnt <= CNT_W'(fir_pkg::NUM_TAPS)
  ) else $error("fill count above tap count");

endmodule

// ==== source/frame_pkg.sv ====
// Framing definitions
// Filtered sample struct passed from the MAC to the frame collector
// Default frame length

package frame_pkg;

  //////////////////////////////////////////////////////////////////////
  // Frame geometry
  //////////////////////////////////////////////////////////////////////

  localparam int FRAME_LEN_DEFAULT = 16;  // Words per frame for the transform stage

  //////////////////////////////////////////////////////////////////////
  // Filtered sample
  //////////////////////////////////////////////////////////////////////

  // One filtered word with its strobe
  // The strobe is high for a single cycle per word
  typedef struct packed {
    logic              valid;  // Data is a new filtered sample
    fir_pkg::sample_t  data;   // Rounded 16 bit filter output
  } fir_out_t;

endpackage

// ==== source/fir_pkg.sv ====
// FIR filter definitions
// Sample, coefficient and accumulator types
// Tap count, output shift and the symmetric Q16 low-pass coefficient table

package fir_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [15:0] sample_t;  // Input or filtered sample
  typedef logic signed [19:0] coef_t;    // Q16 coefficient
  typedef logic signed [47:0] acc_t;     // Holds the sum of 32 products with headroom

  //////////////////////////////////////////////////////////////////////
  // Filter constants
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_TAPS  = 32;
  localparam int OUT_SHIFT = 16;         // Fraction bits dropped on output

  // Low-pass response in order C00 to C31
  // Index k multiplies tap k, where tap 0 is the newest sample
  localparam coef_t FIR_COEFS [NUM_TAPS] = '{
    20'shFFF9E, 20'shFFF86, 20'shFFFA7, 20'sh0003B,  // C00 to C03
    20'sh0014B, 20'sh0024A, 20'sh00222, 20'shFFFE4,  // C04 to C07
    20'shFFBC5, 20'shFF7CA, 20'shFF74E, 20'shFFD74,  // C08 to C11
    20'sh00B1A, 20'sh01DAC, 20'sh02F9E, 20'sh03AA9,  // C12 to C15 with the peak at C15
    20'sh03AA9, 20'sh02F9E, 20'sh01DAC, 20'sh00B1A,  // C16 to C19 mirror C15 down to C12
    20'shFFD74, 20'shFF74E, 20'shFF7CA, 20'shFFBC5,  // C20 to C23
    20'shFFFE4, 20'sh00222, 20'sh0024A, 20'sh0014B,  // C24 to C27
    20'sh0003B, 20'shFFFA7, 20'shFFF86, 20'shFFF9E   // C28 to C31
  };

endpackage
